//--- flist.f
holy_pkg.sv
fetch_stage.sv
decode_stage.sv
regfile.sv
execute_stage.sv
memory_stage.sv
holy_core_top.sv
tb_ref_model.sv
tb_holy_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0
TOP       := tb_holy_core
FLIST     := flist.f
BUILD_DIR := obj_dir
LOG       := sim.log

SOURCES := $(shell grep -v '^+' $(FLIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "Testbench passed" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_holy_core.sv
// ####################
// Random program run against the reference model for a fixed number of cycles
// Program at 0x000 and data at 0x400 in 64-word windows
// ####################
module tb_holy_core;

    timeunit 1ns;
    timeprecision 1ps;

    logic               clk;
    logic               rst_n;
    logic               stall;
    holy_pkg::word_t    imem_addr;
    holy_pkg::word_t    imem_data;
    holy_pkg::word_t    dmem_addr;
    holy_pkg::word_t    dmem_wdata;
    holy_pkg::word_t    dmem_rdata;
    holy_pkg::byte_en_t dmem_be;
    logic               dmem_we;
    holy_pkg::word_t    imem [tb_ref_model::window_words];
    holy_pkg::word_t    dmem [tb_ref_model::window_words];
    holy_pkg::word_t    prev_pc;
    logic               was_stalled;
    int                 errors;
    int                 checks;
    int                 cycle;
    logic               left_window;

    holy_core_top u_dut (
        .clk(clk), .rst_n(rst_n), .i_stall(stall),
        .o_imem_addr(imem_addr), .i_imem_data(imem_data),
        .o_dmem_addr(dmem_addr), .o_dmem_wdata(dmem_wdata), .o_dmem_be(dmem_be),
        .o_dmem_we(dmem_we), .i_dmem_rdata(dmem_rdata)
    );

    assign imem_data  = imem[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    // Enabled lanes are written at the edge
    always @(posedge clk) begin
        if (dmem_we) begin
            for (int i = 0; i < 4; i++) begin
                if (dmem_be[i]) begin
                    dmem[dmem_addr[7:2]][8*i +: 8] <= dmem_wdata[8*i +: 8];
                end
            end
        end
    end

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_mismatch(input string msg);
        errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    // Depends on every address bit so lane and word mix-ups show
    function automatic holy_pkg::word_t fill_word(input holy_pkg::word_t addr);
        return (addr * 32'h9e3779b1) ^ {addr[15:0], ~addr[15:0]};
    endfunction

    function automatic holy_pkg::word_t lane_mask(input holy_pkg::byte_en_t be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    // Offset inside the data window aligned to the access size
    function automatic logic [11:0] data_offset(input logic [1:0] size, input logic [7:0] low);
        logic [11:0] off;
        off = tb_ref_model::data_base[11:0] + {4'h0, low};
        if (size == 2'b01) begin
            off[0] = 1'b0;
        end else if (size == 2'b10) begin
            off[1:0] = 2'b00;
        end
        return off;
    endfunction

    // Jumps and branches only go forward so no tight loop can trap the run
    function automatic holy_pkg::word_t random_instr(input int idx);
        holy_pkg::word_t fld, ctl, val, off, tgt;
        logic [4:0]      rd, rs1, rs2;
        logic [2:0]      f3;
        logic [11:0]     imm;
        fld = tb_ref_model::rand_bits(15);
        ctl = tb_ref_model::rand_bits(8);
        val = tb_ref_model::rand_bits(20);
        off = (1 + tb_ref_model::rand_bits(6) % (63 - idx)) * 4;
        rd  = fld[4:0];
        rs1 = fld[9:5];
        rs2 = fld[14:10];
        f3  = ctl[6:4];
        imm = val[11:0];
        case (ctl[3:0])
            4'd0, 4'd1, 4'd2, 4'd3: begin
                return {(ctl[7] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                        rs2, rs1, f3, rd, holy_pkg::op_reg};
            end
            4'd4, 4'd5, 4'd6, 4'd7: begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    imm[11:5] = (f3 == 3'd5 && ctl[7]) ? 7'h20 : 7'h00;
                end
                return {imm, rs1, f3, rd, holy_pkg::op_imm};
            end
            4'd8: return {val[19:0], rd, holy_pkg::op_lui};
            4'd9: return {val[19:0], rd, holy_pkg::op_auipc};
            4'd10, 4'd11: begin
                // LB LH LW LBU LHU based on x0
                if (f3[1:0] == 2'b11) begin
                    f3 = 3'd2;
                end else if (f3 == 3'd6) begin
                    f3 = 3'd4;
                end
                return {data_offset(f3[1:0], val[7:0]), 5'd0, f3, rd, holy_pkg::op_load};
            end
            4'd12, 4'd13: begin
                f3  = (ctl[5:4] == 2'b11) ? 3'd2 : {1'b0, ctl[5:4]};
                imm = data_offset(f3[1:0], val[7:0]);
                return {imm[11:5], rs2, 5'd0, f3, imm[4:0], holy_pkg::op_store};
            end
            4'd14: begin
                if (f3[2:1] == 2'b01) begin
                    f3[2] = 1'b1;
                end
                return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11],
                        holy_pkg::op_branch};
            end
            default: begin
                if (ctl[7]) begin
                    tgt = off + idx * 4;
                    return {tgt[11:0], 5'd0, 3'd0, rd, holy_pkg::op_jalr};
                end
                return {off[20], off[10:1], off[11], off[19:12], rd, holy_pkg::op_jal};
            end
        endcase
    endfunction

    // Sampled at the falling edge while stall is steady for the coming edge
    // The model steps only when that edge executes the instruction
    task automatic check_cycle();
        holy_pkg::word_t mask;
        checks++;
        assert (imem_addr == tb_ref_model::pc)
            else report_mismatch($sformatf("pc %h, model %h", imem_addr, tb_ref_model::pc));
        if (was_stalled) begin
            checks++;
            assert (imem_addr == prev_pc)
                else report_mismatch($sformatf("stalled edge moved pc %h to %h",
                                               prev_pc, imem_addr));
        end
        if (stall) begin
            checks++;
            assert (!dmem_we)
                else report_mismatch("store enable high while stalled");
        end else begin
            tb_ref_model::step(imem[tb_ref_model::pc[7:2]]);
            checks++;
            assert (dmem_we == tb_ref_model::st_valid)
                else report_mismatch($sformatf("store enable %b, model %b",
                                               dmem_we, tb_ref_model::st_valid));
            if (dmem_we && tb_ref_model::st_valid) begin
                mask = lane_mask(tb_ref_model::st_be);
                checks++;
                assert (dmem_addr == tb_ref_model::st_addr && dmem_be == tb_ref_model::st_be &&
                        (dmem_wdata & mask) == (tb_ref_model::st_data & mask))
                    else report_mismatch($sformatf("store %h %b %h, model %h %b %h",
                                                   dmem_addr, dmem_be, dmem_wdata,
                                                   tb_ref_model::st_addr, tb_ref_model::st_be,
                                                   tb_ref_model::st_data));
            end
        end
        prev_pc     = imem_addr;
        was_stalled = stall;
        if (tb_ref_model::pc > 32'hfc) begin
            left_window = 1'b1;
            errors++;
            $display("Program counter left the instruction window at %0t ns", $time);
        end
    endtask

    initial begin
        errors      = 0;
        checks      = 0;
        left_window = 1'b0;
        rst_n       = 1'b0;
        stall       = 1'b1;
        for (int i = 0; i < tb_ref_model::window_words - 1; i++) begin
            imem[i] = random_instr(i);
        end
        // Last word jumps back to address 0 so the program keeps looping
        imem[tb_ref_model::window_words - 1] = {12'd0, 5'd0, 3'd0, 5'd0, holy_pkg::op_jalr};
        for (int i = 0; i < tb_ref_model::window_words; i++) begin
            dmem[i] <= fill_word(tb_ref_model::data_base + 4 * i);
            tb_ref_model::mem[i] = fill_word(tb_ref_model::data_base + 4 * i);
        end
        for (int i = 0; i < 32; i++) begin
            tb_ref_model::regs[i] = '0;
        end
        tb_ref_model::pc = holy_pkg::reset_pc;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        checks++;
        assert (imem_addr == holy_pkg::reset_pc && !dmem_we)
            else report_mismatch($sformatf("after reset pc %h, we %b", imem_addr, dmem_we));
        prev_pc     = imem_addr;
        was_stalled = stall;

        cycle = 0;
        while (cycle < tb_ref_model::run_cycles && !left_window) begin
            @(posedge clk);
            stall <= (tb_ref_model::rand_bits(2) == 0);
            @(negedge clk);
            check_cycle();
            cycle++;
        end

        // Let the last store land before comparing memories
        @(posedge clk);
        stall <= 1'b1;
        @(negedge clk);
        for (int i = 0; i < tb_ref_model::window_words; i++) begin
            checks++;
            assert (dmem[i] == tb_ref_model::mem[i])
                else report_mismatch($sformatf("data word %0d is %h, model %h",
                                               i, dmem[i], tb_ref_model::mem[i]));
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- tb_ref_model.sv
// ####################
// Instruction-level model of the RV32I subset and the stimulus LFSR
// Misaligned accesses are not modelled, generated programs keep them aligned
// ####################
package tb_ref_model;

    localparam int              run_cycles   = 2000;
    localparam int              window_words = 64;
    localparam holy_pkg::word_t data_base    = 32'h400;

    holy_pkg::word_t    regs [32];
    holy_pkg::word_t    pc;
    holy_pkg::word_t    mem [window_words];
    logic               st_valid;
    holy_pkg::word_t    st_addr;
    holy_pkg::byte_en_t st_be;
    holy_pkg::word_t    st_data;
    holy_pkg::word_t    lfsr_state = 32'h0a46e3c9;

    // Galois LFSR, one step per returned bit
    function automatic holy_pkg::word_t rand_bits(input int n);
        holy_pkg::word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
        end
        return r;
    endfunction

    // OP and OP-IMM results, alt selects SUB and SRA
    function automatic holy_pkg::word_t arith(input logic [2:0] f3, input logic alt,
                                              input holy_pkg::word_t a,
                                              input holy_pkg::word_t b);
        holy_pkg::word_t    r;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = a;
        sb = b;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = {31'b0, sa < sb};
            3'd3: r = {31'b0, a < b};
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = sa >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // Applies one instruction to the model and notes the store it makes
    function automatic void step(input holy_pkg::word_t instr);
        holy_pkg::word_t a, b, res, addr, word, next_pc;
        holy_pkg::word_t imm_i, imm_s, imm_b, imm_j;
        logic [2:0]      f3;
        logic            wr;
        logic            take;
        f3       = instr[14:12];
        a        = regs[instr[19:15]];
        b        = regs[instr[24:20]];
        imm_i    = {{20{instr[31]}}, instr[31:20]};
        imm_s    = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        imm_b    = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_j    = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        next_pc  = pc + 4;
        wr       = 1'b1;
        res      = '0;
        st_valid = 1'b0;
        case (instr[6:0])
            holy_pkg::op_lui:   res = {instr[31:12], 12'b0};
            holy_pkg::op_auipc: res = pc + {instr[31:12], 12'b0};
            holy_pkg::op_jal: begin
                res     = pc + 4;
                next_pc = pc + imm_j;
            end
            holy_pkg::op_jalr: begin
                res     = pc + 4;
                next_pc = (a + imm_i) & ~32'd1;
            end
            holy_pkg::op_branch: begin
                wr = 1'b0;
                case (f3)
                    3'd0:    take = (a == b);
                    3'd1:    take = (a != b);
                    3'd4:    take = ($signed(a) < $signed(b));
                    3'd5:    take = ($signed(a) >= $signed(b));
                    3'd6:    take = (a < b);
                    3'd7:    take = (a >= b);
                    default: take = 1'b0;
                endcase
                if (take) begin
                    next_pc = pc + imm_b;
                end
            end
            holy_pkg::op_load: begin
                addr = a + imm_i;
                word = mem[addr[7:2]] >> {addr[1:0], 3'b000};
                case (f3)
                    3'd0:    res = {{24{word[7]}}, word[7:0]};
                    3'd1:    res = {{16{word[15]}}, word[15:0]};
                    3'd4:    res = {24'b0, word[7:0]};
                    3'd5:    res = {16'b0, word[15:0]};
                    default: res = word;
                endcase
            end
            holy_pkg::op_store: begin
                wr       = 1'b0;
                st_valid = 1'b1;
                st_addr  = a + imm_s;
                st_data  = b << {st_addr[1:0], 3'b000};
                case (f3)
                    3'd0:    st_be = 4'b0001 << st_addr[1:0];
                    3'd1:    st_be = 4'b0011 << st_addr[1:0];
                    default: st_be = 4'b1111;
                endcase
                for (int i = 0; i < 4; i++) begin
                    if (st_be[i]) begin
                        mem[st_addr[7:2]][8*i +: 8] = st_data[8*i +: 8];
                    end
                end
            end
            holy_pkg::op_imm: res = arith(f3, (f3 == 3'd5) && instr[30], a, imm_i);
            holy_pkg::op_reg: res = arith(f3, instr[30], a, b);
            default:          wr = 1'b0;
        endcase
        if (wr && (instr[11:7] != 5'd0)) begin
            regs[instr[11:7]] = res;
        end
        pc = next_pc;
    endfunction

endpackage

//--- holy_core_top.sv
// ####################
// Both memory ports need combinational reads. i_stall holds all state
// ####################
module holy_core_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_stall,
    output holy_pkg::word_t     o_imem_addr,
    input  holy_pkg::word_t     i_imem_data,
    output holy_pkg::word_t     o_dmem_addr,
    output holy_pkg::word_t     o_dmem_wdata,
    output holy_pkg::byte_en_t  o_dmem_be,
    output logic                o_dmem_we,
    input  holy_pkg::word_t     i_dmem_rdata
);

    holy_pkg::word_t     pc;
    holy_pkg::word_t     pc_plus4;
    holy_pkg::reg_addr_t rs1;
    holy_pkg::reg_addr_t rs2;
    holy_pkg::reg_addr_t rd;
    holy_pkg::funct3_t   funct3;
    holy_pkg::word_t     imm;
    holy_pkg::alu_op_e   alu_op;
    holy_pkg::alu_src_e  alu_src;
    holy_pkg::add2_src_e add2_src;
    holy_pkg::wb_src_e   wb_src;
    holy_pkg::pc_src_e   pc_src;
    logic                reg_write;
    logic                mem_write;
    logic                is_branch;
    holy_pkg::word_t     rdata1;
    holy_pkg::word_t     rdata2;
    holy_pkg::word_t     alu_result;
    holy_pkg::word_t     add2_result;
    logic                branch_taken;
    holy_pkg::word_t     wb_data;
    logic                wb_valid;
    logic                rf_we;

    assign o_imem_addr = pc;
    assign o_dmem_addr = alu_result;
    assign rf_we       = reg_write && wb_valid && !i_stall;

    fetch_stage u_fetch (
        .clk(clk), .rst_n(rst_n), .i_stall(i_stall), .i_pc_src(pc_src),
        .i_target(add2_result), .o_pc(pc), .o_pc_plus4(pc_plus4)
    );

    // The data port has no read strobe, so mem_read stays open
    decode_stage u_decode (
        .i_instr(i_imem_data), .i_branch_taken(branch_taken),
        .o_rs1(rs1), .o_rs2(rs2), .o_rd(rd), .o_funct3(funct3), .o_imm(imm),
        .o_alu_op(alu_op), .o_alu_src(alu_src), .o_add2_src(add2_src),
        .o_wb_src(wb_src), .o_pc_src(pc_src), .o_reg_write(reg_write),
        .o_mem_write(mem_write), .o_mem_read(), .o_is_branch(is_branch)
    );

    regfile u_regfile (
        .clk(clk), .rst_n(rst_n), .i_rs1(rs1), .i_rs2(rs2), .i_rd(rd),
        .i_we(rf_we), .i_wdata(wb_data), .o_rdata1(rdata1), .o_rdata2(rdata2)
    );

    execute_stage u_execute (
        .i_pc(pc), .i_rdata1(rdata1), .i_rdata2(rdata2), .i_imm(imm),
        .i_alu_op(alu_op), .i_alu_src(alu_src), .i_add2_src(add2_src),
        .i_is_branch(is_branch), .i_funct3(funct3), .o_alu_result(alu_result),
        .o_add2_result(add2_result), .o_branch_taken(branch_taken)
    );

    memory_stage u_memory (
        .i_stall(i_stall), .i_mem_write(mem_write), .i_funct3(funct3),
        .i_addr(alu_result), .i_store_data(rdata2), .i_dmem_rdata(i_dmem_rdata),
        .i_wb_src(wb_src), .i_alu_result(alu_result), .i_pc_plus4(pc_plus4),
        .i_add2_result(add2_result), .o_dmem_wdata(o_dmem_wdata),
        .o_dmem_be(o_dmem_be), .o_dmem_we(o_dmem_we), .o_wb_data(wb_data),
        .o_wb_valid(wb_valid)
    );

endmodule

//--- memory_stage.sv
// ####################
// Misaligned accesses raise nothing and address bits 1:0 only pick the lanes
// ####################
module memory_stage (
    input  logic                i_stall,
    input  logic                i_mem_write,
    input  holy_pkg::funct3_t   i_funct3,
    input  holy_pkg::word_t     i_addr,
    input  holy_pkg::word_t     i_store_data,
    input  holy_pkg::word_t     i_dmem_rdata,
    input  holy_pkg::wb_src_e   i_wb_src,
    input  holy_pkg::word_t     i_alu_result,
    input  holy_pkg::word_t     i_pc_plus4,
    input  holy_pkg::word_t     i_add2_result,
    output holy_pkg::word_t     o_dmem_wdata,
    output holy_pkg::byte_en_t  o_dmem_be,
    output logic                o_dmem_we,
    output holy_pkg::word_t     o_wb_data,
    output logic                o_wb_valid
);

    logic [7:0]      ld_byte;
    logic [15:0]     ld_half;
    holy_pkg::word_t load_data;
    logic            load_valid;

    assign o_dmem_we = i_mem_write && !i_stall;

    // Store data is replicated so every lane carries the value
    always_comb begin
        case (i_funct3[1:0])
            2'b00: begin
                o_dmem_wdata = {4{i_store_data[7:0]}};
                o_dmem_be    = 4'b0001 << i_addr[1:0];
            end
            2'b01: begin
                o_dmem_wdata = {2{i_store_data[15:0]}};
                o_dmem_be    = i_addr[1] ? 4'b1100 : 4'b0011;
            end
            2'b10: begin
                o_dmem_wdata = i_store_data;
                o_dmem_be    = 4'b1111;
            end
            default: begin
                o_dmem_wdata = i_store_data;
                o_dmem_be    = 4'b0000;
            end
        endcase
    end

    always_comb begin
        case (i_addr[1:0])
            2'd0:    ld_byte = i_dmem_rdata[7:0];
            2'd1:    ld_byte = i_dmem_rdata[15:8];
            2'd2:    ld_byte = i_dmem_rdata[23:16];
            default: ld_byte = i_dmem_rdata[31:24];
        endcase
        ld_half    = i_addr[1] ? i_dmem_rdata[31:16] : i_dmem_rdata[15:0];
        load_valid = 1'b1;
        case (i_funct3)
            3'b000: load_data = {{24{ld_byte[7]}}, ld_byte};
            3'b001: load_data = {{16{ld_half[15]}}, ld_half};
            3'b010: load_data = i_dmem_rdata;
            3'b100: load_data = {24'b0, ld_byte};
            3'b101: load_data = {16'b0, ld_half};
            default: begin
                // Unknown load width blocks the register write
                load_data  = i_dmem_rdata;
                load_valid = 1'b0;
            end
        endcase
    end

    always_comb begin
        o_wb_valid = 1'b1;
        case (i_wb_src)
            holy_pkg::wb_mem: begin
                o_wb_data  = load_data;
                o_wb_valid = load_valid;
            end
            holy_pkg::wb_pc4:  o_wb_data = i_pc_plus4;
            holy_pkg::wb_add2: o_wb_data = i_add2_result;
            default:           o_wb_data = i_alu_result;
        endcase
    end

endmodule

//--- execute_stage.sv
// ####################
// ALU, second adder and branch compare. Shifts use operand b bits 4:0
// ####################
module execute_stage (
    input  holy_pkg::word_t     i_pc,
    input  holy_pkg::word_t     i_rdata1,
    input  holy_pkg::word_t     i_rdata2,
    input  holy_pkg::word_t     i_imm,
    input  holy_pkg::alu_op_e   i_alu_op,
    input  holy_pkg::alu_src_e  i_alu_src,
    input  holy_pkg::add2_src_e i_add2_src,
    input  logic                i_is_branch,
    input  holy_pkg::funct3_t   i_funct3,
    output holy_pkg::word_t     o_alu_result,
    output holy_pkg::word_t     o_add2_result,
    output logic                o_branch_taken
);

    holy_pkg::word_t alu_b;
    holy_pkg::word_t add2_base;
    holy_pkg::word_t add2_sum;
    logic            cond;

    assign alu_b = (i_alu_src == holy_pkg::alu_src_imm) ? i_imm : i_rdata2;

    always_comb begin
        case (i_alu_op)
            holy_pkg::alu_sub:    o_alu_result = i_rdata1 - alu_b;
            holy_pkg::alu_and:    o_alu_result = i_rdata1 & alu_b;
            holy_pkg::alu_or:     o_alu_result = i_rdata1 | alu_b;
            holy_pkg::alu_xor:    o_alu_result = i_rdata1 ^ alu_b;
            holy_pkg::alu_slt:    o_alu_result = {{(holy_pkg::xlen-1){1'b0}},
                                                  $signed(i_rdata1) < $signed(alu_b)};
            holy_pkg::alu_sltu:   o_alu_result = {{(holy_pkg::xlen-1){1'b0}},
                                                  i_rdata1 < alu_b};
            holy_pkg::alu_sll:    o_alu_result = i_rdata1 << alu_b[4:0];
            holy_pkg::alu_srl:    o_alu_result = i_rdata1 >> alu_b[4:0];
            holy_pkg::alu_sra:    o_alu_result = $signed(i_rdata1) >>> alu_b[4:0];
            holy_pkg::alu_pass_b: o_alu_result = alu_b;
            default:              o_alu_result = i_rdata1 + alu_b;
        endcase
    end

    // Second adder for branch, jump and AUIPC targets
    assign add2_base = (i_add2_src == holy_pkg::add2_rs1) ? i_rdata1 : i_pc;
    assign add2_sum  = add2_base + i_imm;

    // Only JALR uses the rs1 base and it clears bit 0
    assign o_add2_result = (i_add2_src == holy_pkg::add2_rs1) ?
                           {add2_sum[holy_pkg::xlen-1:1], 1'b0} : add2_sum;

    always_comb begin
        case (i_funct3)
            3'b000:  cond = (i_rdata1 == i_rdata2);
            3'b001:  cond = (i_rdata1 != i_rdata2);
            3'b100:  cond = ($signed(i_rdata1) < $signed(i_rdata2));
            3'b101:  cond = ($signed(i_rdata1) >= $signed(i_rdata2));
            3'b110:  cond = (i_rdata1 < i_rdata2);
            3'b111:  cond = (i_rdata1 >= i_rdata2);
            default: cond = 1'b0;
        endcase
    end

    assign o_branch_taken = i_is_branch && cond;

endmodule

//--- regfile.sv
// ####################
// x0 reads zero since its writes are dropped and reset clears it
// ####################
module regfile (
    input  logic                clk,
    input  logic                rst_n,
    input  holy_pkg::reg_addr_t i_rs1,
    input  holy_pkg::reg_addr_t i_rs2,
    input  holy_pkg::reg_addr_t i_rd,
    input  logic                i_we,
    input  holy_pkg::word_t     i_wdata,
    output holy_pkg::word_t     o_rdata1,
    output holy_pkg::word_t     o_rdata2
);

    holy_pkg::word_t regs [2**$bits(holy_pkg::reg_addr_t)];

    // Asynchronous reads for the single-cycle datapath
    assign o_rdata1 = regs[i_rs1];
    assign o_rdata2 = regs[i_rs2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < $size(regs); i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_rd != '0)) begin
            regs[i_rd] <= i_wdata;
        end
    end

endmodule

//--- decode_stage.sv
// ####################
// FENCE, ECALL and EBREAK are treated as unknown opcodes
// Unknown opcodes write nothing and continue at PC+4
// ####################
module decode_stage (
    input  holy_pkg::word_t     i_instr,
    input  logic                i_branch_taken,
    output holy_pkg::reg_addr_t o_rs1,
    output holy_pkg::reg_addr_t o_rs2,
    output holy_pkg::reg_addr_t o_rd,
    output holy_pkg::funct3_t   o_funct3,
    output holy_pkg::word_t     o_imm,
    output holy_pkg::alu_op_e   o_alu_op,
    output holy_pkg::alu_src_e  o_alu_src,
    output holy_pkg::add2_src_e o_add2_src,
    output holy_pkg::wb_src_e   o_wb_src,
    output holy_pkg::pc_src_e   o_pc_src,
    output logic                o_reg_write,
    output logic                o_mem_write,
    output logic                o_mem_read,
    output logic                o_is_branch
);

    logic [6:0]         opcode;
    logic [6:0]         funct7;
    logic               is_jump;
    holy_pkg::imm_src_e imm_src;

    // Shared by the OP and OP-IMM groups, alt is instruction bit 30
    function automatic holy_pkg::alu_op_e arith_op(input holy_pkg::funct3_t f3,
                                                   input logic alt);
        holy_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = alt ? holy_pkg::alu_sub : holy_pkg::alu_add;
            3'b001:  op = holy_pkg::alu_sll;
            3'b010:  op = holy_pkg::alu_slt;
            3'b011:  op = holy_pkg::alu_sltu;
            3'b100:  op = holy_pkg::alu_xor;
            3'b101:  op = alt ? holy_pkg::alu_sra : holy_pkg::alu_srl;
            3'b110:  op = holy_pkg::alu_or;
            default: op = holy_pkg::alu_and;
        endcase
        return op;
    endfunction

    assign opcode   = i_instr[6:0];
    assign funct7   = i_instr[31:25];
    assign o_rd     = i_instr[11:7];
    assign o_funct3 = i_instr[14:12];
    assign o_rs1    = i_instr[19:15];
    assign o_rs2    = i_instr[24:20];

    always_comb begin
        imm_src     = holy_pkg::imm_i;
        o_alu_op    = holy_pkg::alu_add;
        o_alu_src   = holy_pkg::alu_src_reg;
        o_add2_src  = holy_pkg::add2_pc;
        o_wb_src    = holy_pkg::wb_alu;
        o_reg_write = 1'b0;
        o_mem_write = 1'b0;
        o_mem_read  = 1'b0;
        o_is_branch = 1'b0;
        is_jump     = 1'b0;
        case (opcode)
            holy_pkg::op_lui: begin
                imm_src     = holy_pkg::imm_u;
                o_alu_op    = holy_pkg::alu_pass_b;
                o_alu_src   = holy_pkg::alu_src_imm;
                o_reg_write = 1'b1;
            end
            holy_pkg::op_auipc: begin
                imm_src     = holy_pkg::imm_u;
                o_wb_src    = holy_pkg::wb_add2;
                o_reg_write = 1'b1;
            end
            holy_pkg::op_jal: begin
                imm_src     = holy_pkg::imm_j;
                o_wb_src    = holy_pkg::wb_pc4;
                o_reg_write = 1'b1;
                is_jump     = 1'b1;
            end
            holy_pkg::op_jalr: begin
                o_add2_src  = holy_pkg::add2_rs1;
                o_wb_src    = holy_pkg::wb_pc4;
                o_reg_write = 1'b1;
                is_jump     = 1'b1;
            end
            holy_pkg::op_branch: begin
                imm_src     = holy_pkg::imm_b;
                o_is_branch = 1'b1;
            end
            holy_pkg::op_load: begin
                o_alu_src   = holy_pkg::alu_src_imm;
                o_wb_src    = holy_pkg::wb_mem;
                o_reg_write = 1'b1;
                o_mem_read  = 1'b1;
            end
            holy_pkg::op_store: begin
                imm_src     = holy_pkg::imm_s;
                o_alu_src   = holy_pkg::alu_src_imm;
                o_mem_write = 1'b1;
            end
            holy_pkg::op_imm: begin
                // ADDI has no subtract form, bit 30 only selects SRAI
                o_alu_op    = arith_op(o_funct3, (o_funct3 == 3'b101) && funct7[5]);
                o_alu_src   = holy_pkg::alu_src_imm;
                o_reg_write = 1'b1;
            end
            holy_pkg::op_reg: begin
                o_alu_op    = arith_op(o_funct3, funct7[5]);
                o_reg_write = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (imm_src)
            holy_pkg::imm_s: o_imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            holy_pkg::imm_b: o_imm = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                                      i_instr[30:25], i_instr[11:8], 1'b0};
            holy_pkg::imm_u: o_imm = {i_instr[31:12], 12'b0};
            holy_pkg::imm_j: o_imm = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
                                      i_instr[20], i_instr[30:21], 1'b0};
            default:         o_imm = {{20{i_instr[31]}}, i_instr[31:20]};
        endcase
    end

    // Branch outcome comes back from execute
    assign o_pc_src = (is_jump || (o_is_branch && i_branch_taken)) ?
                      holy_pkg::pc_add2 : holy_pkg::pc_plus4;

endmodule

//--- fetch_stage.sv
// ####################
// PC register. Targets are taken as given and never checked for alignment
// ####################
module fetch_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_stall,
    input  holy_pkg::pc_src_e   i_pc_src,
    input  holy_pkg::word_t     i_target,
    output holy_pkg::word_t     o_pc,
    output holy_pkg::word_t     o_pc_plus4
);

    holy_pkg::word_t pc_next;

    assign o_pc_plus4 = o_pc + holy_pkg::word_t'(4);
    assign pc_next    = (i_pc_src == holy_pkg::pc_add2) ? i_target : o_pc_plus4;

    // A stalled edge presents the same instruction again
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_pc <= holy_pkg::reset_pc;
        end else if (!i_stall) begin
            o_pc <= pc_next;
        end
    end

endmodule

//--- holy_pkg.sv
// ####################
// Shared widths, opcodes and decode selects of the single-cycle RV32I core
// No CSR, trap or FENCE encodings are defined here
// ####################
package holy_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [3:0]      byte_en_t;
    typedef logic [2:0]      funct3_t;

    // Major opcodes of the supported subset
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    localparam word_t reset_pc = '0;

    typedef enum logic [2:0] {
        imm_i,
        imm_s,
        imm_b,
        imm_u,
        imm_j
    } imm_src_e;

    // LUI goes through the ALU as a pass of operand b
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass_b
    } alu_op_e;

    typedef enum logic {alu_src_reg, alu_src_imm} alu_src_e;
    typedef enum logic {add2_pc, add2_rs1} add2_src_e;
    typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc4, wb_add2} wb_src_e;
    typedef enum logic {pc_plus4, pc_add2} pc_src_e;

endpackage
